// ==== rdma_pkg.sv ====
/*
  RDMA request parser definitions.
  Field widths, the command opcodes and the packed request words
  shared by the router, the read splitter, the merger and the slices.
*/

package rdma_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Virtual address in host or card memory
  localparam int VADDR_BITS = 48;
  // Transfer length in bytes
  localparam int LEN_BITS = 28;
  // Process id of the issuing context
  localparam int PID_BITS = 6;
  // Destination stream or queue index
  localparam int DEST_BITS = 4;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Only reads get split, the others bypass
  typedef enum logic [1:0] {
    RDMA_READ  = 2'd0,
    RDMA_WRITE = 2'd1,
    RDMA_SEND  = 2'd2
  } rdma_op_t;

  ////////////////////////////////////////////////////////////
  // Request words
  ////////////////////////////////////////////////////////////

  // Local side of a command, 90 bits
  typedef struct packed {
    rdma_op_t               opcode;
    logic [PID_BITS-1:0]    pid;
    logic [DEST_BITS-1:0]   dest;
    // Host memory vs card memory
    logic                   host;
    // Final piece of a user transfer
    logic                   last;
    logic [VADDR_BITS-1:0]  vaddr;
    logic [LEN_BITS-1:0]    len;
  } rdma_local_t;

  // Remote side of a command, 52 bits
  typedef struct packed {
    logic [VADDR_BITS-1:0]  vaddr;
    logic [DEST_BITS-1:0]   dest;
  } rdma_remote_t;

  // Double request, data word of every request stream
  typedef struct packed {
    rdma_local_t   req_1;
    rdma_remote_t  req_2;
  } rdma_dreq_t;

endpackage

// ==== meta_reg.sv ====
/*
  Request stream register slice.
  Two entries: a main output register and a skid register,
  so ready toward the producer is a flop and throughput stays full.
*/

`timescale 1ns/10ps

module meta_reg (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  rdma_pkg::rdma_dreq_t s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output rdma_pkg::rdma_dreq_t m_data
);

  logic                 main_valid_q;
  logic                 skid_valid_q;
  rdma_pkg::rdma_dreq_t main_data_q;
  rdma_pkg::rdma_dreq_t skid_data_q;
  logic                 load_main;

  // Main entry free or draining this cycle
  assign load_main = m_ready | ~main_valid_q;

  // Only a full skid entry blocks the producer
  assign s_ready = ~skid_valid_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_main) begin
      // Skid wins over new input, input is blocked then anyway
      main_valid_q <= skid_valid_q | s_valid;
      skid_valid_q <= 1'b0;
    end else if (s_valid && !skid_valid_q) begin
      // Main stalled, park the incoming item
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_main) begin
      main_data_q <= skid_valid_q ? skid_data_q : s_data;
    end else if (s_valid && !skid_valid_q) begin
      skid_data_q <= s_data;
    end
  end

  assign m_valid = main_valid_q;
  assign m_data  = main_data_q;

  // Offered word holds until the consumer takes it
  a_hold_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

// ==== rdma_cmd_router.sv ====
/*
  RDMA command router.
  Registers each host command, decodes its opcode and offers it
  to the read splitter path or to the write/send bypass path.
*/

`timescale 1ns/10ps

module rdma_cmd_router (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  rdma_pkg::rdma_dreq_t s_data,
  output logic                 rd_valid,
  input  logic                 rd_ready,
  output rdma_pkg::rdma_dreq_t rd_data,
  output logic                 bp_valid,
  input  logic                 bp_ready,
  output rdma_pkg::rdma_dreq_t bp_data
);

  logic                 reg_valid;
  logic                 reg_ready;
  rdma_pkg::rdma_dreq_t reg_data;
  logic                 is_read;

  // Input stage, one cycle of latency
  meta_reg inst_in_reg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (reg_valid),
    .m_ready (reg_ready),
    .m_data  (reg_data)
  );

  ////////////////////////////////////////////////////////////
  // Opcode steering
  ////////////////////////////////////////////////////////////

  assign is_read = (reg_data.req_1.opcode == rdma_pkg::RDMA_READ);

  // Valid goes to one path only
  assign rd_valid = reg_valid & is_read;
  assign bp_valid = reg_valid & ~is_read;

  // Ready comes back from the selected path alone
  assign reg_ready = is_read ? rd_ready : bp_ready;

  // Same word on both paths, the valids do the selecting
  assign rd_data = reg_data;
  assign bp_data = reg_data;

  // Host side must never issue an undefined opcode
  a_known_opcode: assert property (@(posedge aclk) disable iff (!aresetn)
    reg_valid |-> reg_data.req_1.opcode inside
      {rdma_pkg::RDMA_READ, rdma_pkg::RDMA_WRITE, rdma_pkg::RDMA_SEND});

endmodule

// ==== rdma_read_splitter.sv ====
/*
  RDMA read splitter.
  Cuts one read command into pieces of at most MAX_READ_BYTES.
  Local and remote addresses advance together by the piece size;
  only the final piece carries the command's last bit.
*/

`timescale 1ns/10ps

module rdma_read_splitter #(
  parameter int unsigned MAX_READ_BYTES = 4096
) (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  rdma_pkg::rdma_dreq_t s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output rdma_pkg::rdma_dreq_t m_data
);

  // Piece size at length and address width
  localparam logic [rdma_pkg::LEN_BITS-1:0] MAX_LEN =
    MAX_READ_BYTES[rdma_pkg::LEN_BITS-1:0];
  localparam logic [rdma_pkg::VADDR_BITS-1:0] MAX_ADDR =
    {{(rdma_pkg::VADDR_BITS-rdma_pkg::LEN_BITS){1'b0}}, MAX_LEN};

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PARSE,
    ST_SEND
  } state_t;

  state_t state_q;
  state_t state_d;

  // Remaining command: len counts down, both vaddrs advance
  rdma_pkg::rdma_dreq_t cmd_q;
  // Piece on offer at the output
  rdma_pkg::rdma_dreq_t piece_q;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (s_valid) begin
          state_d = ST_PARSE;
        end
      end
      ST_PARSE: begin
        state_d = ST_SEND;
      end
      ST_SEND: begin
        // Zero remaining length means the final piece is out
        if (m_ready) begin
          state_d = (cmd_q.req_1.len != '0) ? ST_PARSE : ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    case (state_q)
      ST_IDLE: begin
        if (s_valid) begin
          cmd_q <= s_data;
        end
      end
      ST_PARSE: begin
        // Piece starts at the current addresses, other fields copied
        piece_q <= cmd_q;
        if (cmd_q.req_1.len > MAX_LEN) begin
          // Full-size piece, more to follow
          piece_q.req_1.len  <= MAX_LEN;
          piece_q.req_1.last <= 1'b0;
          cmd_q.req_1.len    <= cmd_q.req_1.len - MAX_LEN;
          cmd_q.req_1.vaddr  <= cmd_q.req_1.vaddr + MAX_ADDR;
          cmd_q.req_2.vaddr  <= cmd_q.req_2.vaddr + MAX_ADDR;
        end else begin
          // Tail piece keeps its own len and last bit
          cmd_q.req_1.len <= '0;
        end
      end
      default: begin
      end
    endcase
  end

  // Commands taken only between reads
  assign s_ready = (state_q == ST_IDLE);

  assign m_valid = (state_q == ST_SEND);
  assign m_data  = piece_q;

  // No piece may exceed the protocol's single read size
  a_piece_len: assert property (@(posedge aclk) disable iff (!aresetn)
    m_valid |-> m_data.req_1.len <= MAX_LEN);

endmodule

// ==== rdma_req_merger.sv ====
/*
  RDMA request merger.
  Round-robin arbiter between read pieces and bypassed commands.
  A grant stays locked on a waiting source until its item is taken,
  then priority passes to the other source. Output is registered.
*/

`timescale 1ns/10ps

module rdma_req_merger (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 rd_valid,
  output logic                 rd_ready,
  input  rdma_pkg::rdma_dreq_t rd_data,
  input  logic                 bp_valid,
  output logic                 bp_ready,
  input  rdma_pkg::rdma_dreq_t bp_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output rdma_pkg::rdma_dreq_t m_data
);

  // Select encoding, 0 is the read stream and 1 the bypass stream
  logic                 sel;
  logic                 lock_q;
  logic                 lock_sel_q;
  logic                 prio_q;
  logic                 arb_valid;
  logic                 arb_ready;
  rdma_pkg::rdma_dreq_t arb_data;

  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (rd_valid && bp_valid) begin
      sel = prio_q;
    end else begin
      // Single requester or none
      sel = bp_valid;
    end
  end

  assign arb_valid = sel ? bp_valid : rd_valid;
  assign arb_data  = sel ? bp_data : rd_data;
  assign rd_ready  = arb_ready & ~sel;
  assign bp_ready  = arb_ready & sel;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
      prio_q     <= 1'b0;
    end else if (arb_valid && arb_ready) begin
      // Accepted, release and hand priority over
      lock_q <= 1'b0;
      prio_q <= ~sel;
    end else if (arb_valid) begin
      lock_q     <= 1'b1;
      lock_sel_q <= sel;
    end
  end

  // Output slice
  meta_reg inst_out_reg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (arb_valid),
    .s_ready (arb_ready),
    .s_data  (arb_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  // Stalled grant keeps offering the same word
  a_grant_held: assert property (@(posedge aclk) disable iff (!aresetn)
    arb_valid && !arb_ready |=> arb_valid && $stable(arb_data));

endmodule

// ==== rdma_req_parser.sv ====
/*
  RDMA request parser, top level.
  Routes host commands by opcode, splits reads into protocol-sized
  pieces, passes writes and sends through and merges both streams.
*/

`timescale 1ns/10ps

module rdma_req_parser #(
  parameter int unsigned MAX_READ_BYTES = 4096
) (
  input  logic                 aclk,
  input  logic                 aresetn,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  rdma_pkg::rdma_dreq_t s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output rdma_pkg::rdma_dreq_t m_data
);

  // Router to splitter and to bypass slice
  logic rd_valid, rd_ready;
  logic bp_valid, bp_ready;
  rdma_pkg::rdma_dreq_t rd_data;
  rdma_pkg::rdma_dreq_t bp_data;

  // Into the merger
  logic piece_valid, piece_ready;
  logic bp_out_valid, bp_out_ready;
  rdma_pkg::rdma_dreq_t piece_data;
  rdma_pkg::rdma_dreq_t bp_out_data;

  rdma_cmd_router inst_router (
    .aclk (aclk), .aresetn (aresetn),
    .s_valid (s_valid), .s_ready (s_ready), .s_data (s_data),
    .rd_valid (rd_valid), .rd_ready (rd_ready), .rd_data (rd_data),
    .bp_valid (bp_valid), .bp_ready (bp_ready), .bp_data (bp_data)
  );

  rdma_read_splitter #(.MAX_READ_BYTES(MAX_READ_BYTES)) inst_splitter (
    .aclk (aclk), .aresetn (aresetn),
    .s_valid (rd_valid), .s_ready (rd_ready), .s_data (rd_data),
    .m_valid (piece_valid), .m_ready (piece_ready), .m_data (piece_data)
  );

  // Writes and sends, one slice to balance the path
  meta_reg inst_bp_reg (
    .aclk (aclk), .aresetn (aresetn),
    .s_valid (bp_valid), .s_ready (bp_ready), .s_data (bp_data),
    .m_valid (bp_out_valid), .m_ready (bp_out_ready), .m_data (bp_out_data)
  );

  rdma_req_merger inst_merger (
    .aclk (aclk), .aresetn (aresetn),
    .rd_valid (piece_valid), .rd_ready (piece_ready), .rd_data (piece_data),
    .bp_valid (bp_out_valid), .bp_ready (bp_out_ready), .bp_data (bp_out_data),
    .m_valid (m_valid), .m_ready (m_ready), .m_data (m_data)
  );

endmodule

// ==== rdma_req_parser_tb.sv ====
/*
  Testbench for the RDMA request parser.
  Drives random reads, writes and sends from an xorshift source,
  expands each accepted command with a read-splitting model into
  per-stream expected queues and checks every output field.
*/

`timescale 1ns/10ps

module rdma_req_parser_tb;

  localparam logic [31:0] SEED = 32'h8672891e;
  localparam logic [31:0] MAX = 32'd4096;
  // Cycle limit for each wait loop
  localparam int TIMEOUT = 4000;

  logic                 aclk;
  logic                 aresetn;
  logic                 s_valid;
  logic                 s_ready;
  rdma_pkg::rdma_dreq_t s_data;
  logic                 m_valid;
  logic                 m_ready = 1'b0;
  rdma_pkg::rdma_dreq_t m_data;

  // Expected outputs, one queue per stream
  rdma_pkg::rdma_dreq_t exp_rd[$];
  rdma_pkg::rdma_dreq_t exp_bp[$];

  int          errors = 0;
  int          timeouts = 0;
  int          others = 0;
  string       test_name = "reset_state";
  logic        random_ready = 1'b0;
  logic [31:0] stim_state = SEED;
  logic [31:0] rdy_state = ~SEED;

  rdma_req_parser #(.MAX_READ_BYTES(MAX)) dut0 (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////
  // Random source and command builder
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // Mostly 1 to 3*MAX, now and then an exact multiple or zero
  function automatic logic [rdma_pkg::LEN_BITS-1:0] random_len();
    logic [31:0] r;
    r = rand32();
    if (r[2:0] == 3'd0) begin
      return 28'(MAX * r[4:3]);
    end
    return 28'(1 + rand32() % (3 * MAX));
  endfunction

  function automatic rdma_pkg::rdma_dreq_t make_cmd(input rdma_pkg::rdma_op_t op,
                                                   input logic [27:0] len);
    rdma_pkg::rdma_dreq_t cmd;
    logic [31:0] r;
    r = rand32();
    cmd.req_1.opcode = op;
    cmd.req_1.pid    = r[5:0];
    cmd.req_1.dest   = r[9:6];
    cmd.req_1.host   = r[10];
    cmd.req_1.last   = r[11];
    cmd.req_1.len    = len;
    cmd.req_2.dest   = r[15:12];
    cmd.req_1.vaddr  = {r[31:16], rand32()};
    cmd.req_2.vaddr  = {rand32(), r[31:16]};
    return cmd;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////////////////////////

  // Reads become n = ceil(L/MAX) pieces, everything else passes as is
  task automatic expand_cmd(input rdma_pkg::rdma_dreq_t cmd);
    rdma_pkg::rdma_dreq_t piece;
    logic [31:0] total;
    logic [31:0] n;
    logic [31:0] k;
    if (cmd.req_1.opcode != rdma_pkg::RDMA_READ) begin
      exp_bp.push_back(cmd);
    end else begin
      total = 32'(cmd.req_1.len);
      // Zero length still yields one piece
      n = (total == 0) ? 1 : (total + MAX - 1) / MAX;
      for (k = 0; k < n; k++) begin
        piece = cmd;
        piece.req_1.vaddr = cmd.req_1.vaddr + 48'(k * MAX);
        piece.req_2.vaddr = cmd.req_2.vaddr + 48'(k * MAX);
        if (k == n - 1) begin
          // Tail keeps the command's last bit
          piece.req_1.len = 28'(total - k * MAX);
        end else begin
          piece.req_1.len  = 28'(MAX);
          piece.req_1.last = 1'b0;
        end
        exp_rd.push_back(piece);
      end
    end
  endtask

  task automatic check_field(input string field, input logic [63:0] want,
                             input logic [63:0] got);
    if (want !== got) begin
      errors++;
      $display("** Error [%s] %s: expected %0h, actual %0h", test_name, field, want, got);
    end
  endtask

  task automatic check_output(input rdma_pkg::rdma_dreq_t got);
    rdma_pkg::rdma_dreq_t want;
    logic have;
    have = 1'b0;
    if (got.req_1.opcode == rdma_pkg::RDMA_READ) begin
      if (exp_rd.size() != 0) begin
        want = exp_rd.pop_front();
        have = 1'b1;
      end
    end else if (exp_bp.size() != 0) begin
      want = exp_bp.pop_front();
      have = 1'b1;
    end
    if (!have) begin
      others++;
      $display("Output request arrived with nothing expected on its stream in test %s",
               test_name);
    end else begin
      check_field("opcode", 64'(want.req_1.opcode), 64'(got.req_1.opcode));
      check_field("pid", 64'(want.req_1.pid), 64'(got.req_1.pid));
      check_field("dest", 64'(want.req_1.dest), 64'(got.req_1.dest));
      check_field("host", 64'(want.req_1.host), 64'(got.req_1.host));
      check_field("last", 64'(want.req_1.last), 64'(got.req_1.last));
      check_field("vaddr", 64'(want.req_1.vaddr), 64'(got.req_1.vaddr));
      check_field("len", 64'(want.req_1.len), 64'(got.req_1.len));
      check_field("remote vaddr", 64'(want.req_2.vaddr), 64'(got.req_2.vaddr));
      check_field("remote dest", 64'(want.req_2.dest), 64'(got.req_2.dest));
    end
  endtask

  // Both handshakes sampled at the edge, before any flop update
  always @(posedge aclk) begin
    if (aresetn && s_valid && s_ready) begin
      expand_cmd(s_data);
    end
    if (aresetn && m_valid && m_ready) begin
      check_output(m_data);
    end
  end

  // Output back-pressure, own random state
  always @(posedge aclk) begin
    rdy_state = xorshift32(rdy_state);
    m_ready <= !random_ready || rdy_state[3];
  end

  ////////////////////////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////////////////////////

  task automatic finish_run();
    $display("Closing counts: %0d value errors, %0d timeouts, %0d other failures",
             errors, timeouts, others);
    if (errors + timeouts + others == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  // Called on a rising edge, returns on the accepting edge
  task automatic send_cmd(input rdma_pkg::rdma_dreq_t cmd);
    int waited;
    s_valid <= 1'b1;
    s_data  <= cmd;
    waited = 0;
    do begin
      @(posedge aclk);
      waited++;
    end while (!s_ready && waited < TIMEOUT);
    if (!s_ready) begin
      $display("Timeout: command not accepted within %0d cycles in test %s",
               TIMEOUT, test_name);
      timeouts++;
      finish_run();
    end else begin
      s_valid <= 1'b0;
    end
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    do begin
      @(posedge aclk);
      waited++;
    end while ((exp_rd.size() != 0 || exp_bp.size() != 0) && waited < TIMEOUT);
    if (exp_rd.size() != 0 || exp_bp.size() != 0) begin
      $display("Timeout: %0d read pieces and %0d other requests never came out in test %s",
               exp_rd.size(), exp_bp.size(), test_name);
      timeouts++;
      finish_run();
    end
  endtask

  initial begin
    int i;
    logic [31:0] r;
    rdma_pkg::rdma_op_t op;
    aresetn = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    // Empty pipeline straight after reset
    check_field("m_valid", 64'd0, 64'(m_valid));
    check_field("s_ready", 64'd1, 64'(s_ready));

    test_name = "single_reads";
    for (i = 0; i < 20; i++) begin
      send_cmd(make_cmd(rdma_pkg::RDMA_READ, 28'(1 + rand32() % (3 * MAX))));
      drain_outputs();
    end

    // Lengths 0, MAX, 2*MAX, 3*MAX
    test_name = "exact_multiple";
    for (i = 0; i < 4; i++) begin
      send_cmd(make_cmd(rdma_pkg::RDMA_READ, 28'(MAX * i)));
      drain_outputs();
    end

    test_name = "bypass_order";
    for (i = 0; i < 16; i++) begin
      r = rand32();
      op = r[0] ? rdma_pkg::RDMA_WRITE : rdma_pkg::RDMA_SEND;
      send_cmd(make_cmd(op, 28'(r >> 8)));
    end
    drain_outputs();

    test_name = "random_mix";
    for (i = 0; i < 60; i++) begin
      op = rdma_pkg::rdma_op_t'(2'(rand32() % 3));
      send_cmd(make_cmd(op, random_len()));
    end
    drain_outputs();

    test_name = "backpressure";
    random_ready <= 1'b1;
    for (i = 0; i < 60; i++) begin
      op = rdma_pkg::rdma_op_t'(2'(rand32() % 3));
      send_cmd(make_cmd(op, random_len()));
    end
    drain_outputs();
    random_ready <= 1'b0;
    // Idle window, any duplicate would show up here
    repeat (20) @(posedge aclk);
    // Every slice and the splitter empty again
    test_name = "idle_after_drain";
    check_field("m_valid", 64'd0, 64'(m_valid));
    check_field("s_ready", 64'd1, 64'(s_ready));
    finish_run();
  end

endmodule

// ==== rdma_req_parser.f ====
rdma_pkg.sv
meta_reg.sv
rdma_cmd_router.sv
rdma_read_splitter.sv
rdma_req_merger.sv
rdma_req_parser.sv
rdma_req_parser_tb.sv

// ==== Makefile ====
# Verilator flow for the RDMA request parser

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f rdma_req_parser.f --top-module rdma_req_parser

sim:
	verilator --binary --timing --assert -f rdma_req_parser.f \
		--top-module rdma_req_parser_tb -o rdma_req_parser_sim
	@out=$$(./obj_dir/rdma_req_parser_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
